// ==== Makefile ====
# Verilator build and run of the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, run, and pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/fetch_pkg.sv ====
/*
  shared fetch definitions
  superscalar width, address and instruction types,
  major opcode enum and instruction field bounds
*/
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // fetch width and word types
  //////////////////////////////////////////////////////////////////////

  // two instructions per 64-bit memory word
  // the half-word select in fetch only handles a pair
  localparam int NUM_SUPER = 2;

  // byte address into the program
  typedef logic [63:0] addr_t;

  // one instruction, half of a memory word
  typedef logic [31:0] inst_t;

  //////////////////////////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////////////////////////

  // major opcode sits in bits 31..26
  localparam int OPCODE_LSB = 26;

  // branch displacement in bits 20..0, counted in instructions
  localparam int DISP_WIDTH = 21;

  // branch format major opcodes
  // anything not listed here is treated as a non-branch
  typedef enum logic [5:0] {
    OP_JMP = 6'h1a,
    OP_BR  = 6'h30,
    OP_BSR = 6'h34,
    OP_BEQ = 6'h39,
    OP_BLT = 6'h3a,
    OP_BLE = 6'h3b,
    OP_BNE = 6'h3d,
    OP_BGE = 6'h3e,
    OP_BGT = 6'h3f
  } opcode_t;

endpackage

// ==== hdl/fetch_stage.sv ====
/*
  fetch stage
  pc register, aligned memory address, word split into slots,
  raw slot validity and the rollback override
*/
`timescale 1ns/1ps

module fetch_stage #(
  parameter fetch_pkg::addr_t RESET_PC = '0
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         get_next_inst,
  input  logic [63:0]                                  imem_data,
  input  logic                                         imem_valid,
  input  logic                                         rollback_en,
  input  fetch_pkg::addr_t                             rollback_pc,
  input  fetch_pkg::addr_t                             predicted_pc,
  input  logic [fetch_pkg::NUM_SUPER-1:0]              pred_valid,
  output fetch_pkg::addr_t                             imem_addr,
  output fetch_pkg::addr_t                             pc,
  output fetch_pkg::inst_t [fetch_pkg::NUM_SUPER-1:0]  slot_inst,
  output logic [fetch_pkg::NUM_SUPER-1:0]              raw_valid,
  output fetch_pkg::inst_t [fetch_pkg::NUM_SUPER-1:0]  if_ir,
  output logic [fetch_pkg::NUM_SUPER-1:0]              if_valid_inst
);
  import fetch_pkg::*;

  // memory returned a word and decode can take it
  logic  advance;
  // pc loads this cycle
  logic  pc_enable;
  // value loaded into the pc
  addr_t next_pc;

  //////////////////////////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////////////////////////

  // memory is addressed by 64-bit word
  assign imem_addr = {pc[63:3], 3'b000};

  // lower half is slot 0, upper half is slot 1
  for (genvar i = 0; i < NUM_SUPER; i++)
  begin : g_split
    assign slot_inst[i] = imem_data[i*$bits(inst_t) +: $bits(inst_t)];
  end

  // pc bit 2 set means we entered at the upper half
  // so the lower instruction is behind us
  assign raw_valid[0] = imem_valid && !pc[2];
  assign raw_valid[1] = imem_valid;

  //////////////////////////////////////////////////////////////////////
  // decode side
  //////////////////////////////////////////////////////////////////////

  assign if_ir = slot_inst;

  // a redirect kills whatever was fetched on the wrong path
  assign if_valid_inst = rollback_en ? '0 : pred_valid;

  //////////////////////////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////////////////////////

  assign advance = imem_valid && get_next_inst;

  // rollback must load even during a stall or miss
  assign pc_enable = advance || rollback_en;
  assign next_pc   = rollback_en ? rollback_pc : predicted_pc;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc <= RESET_PC;
    end
    else if (pc_enable)
    begin
      pc <= next_pc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // predictor masking must never resurrect a slot from a missing word
  a_valid_needs_word : assert property (
    @(posedge clock) disable iff (reset)
    !imem_valid |-> (if_valid_inst == '0)
  ) else $error("if_valid_inst high while imem_valid low");

  // a stalled cycle keeps presenting the same fetch address
  a_pc_holds : assert property (
    @(posedge clock) disable iff (reset)
    !pc_enable |=> $stable(pc)
  ) else $error("pc changed with the enable low");

endmodule

// ==== hdl/fetch_unit.sv ====
/*
  fetch unit top level
  fetch stage and static predictor between instruction memory
  and decode
*/
`timescale 1ns/1ps

module fetch_unit #(
  parameter fetch_pkg::addr_t RESET_PC = '0
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         get_next_inst,
  input  logic                                         rollback_en,
  input  fetch_pkg::addr_t                             rollback_pc,
  input  logic [63:0]                                  imem_data,
  input  logic                                         imem_valid,
  output fetch_pkg::addr_t                             imem_addr,
  output fetch_pkg::inst_t [fetch_pkg::NUM_SUPER-1:0]  if_ir,
  output fetch_pkg::addr_t [fetch_pkg::NUM_SUPER-1:0]  if_npc,
  output fetch_pkg::addr_t [fetch_pkg::NUM_SUPER-1:0]  if_target,
  output logic [fetch_pkg::NUM_SUPER-1:0]              if_valid_inst
);
  import fetch_pkg::*;

  // stage to predictor
  addr_t                   pc;
  inst_t [NUM_SUPER-1:0]   slot_inst;
  logic  [NUM_SUPER-1:0]   raw_valid;

  // predictor back to stage
  addr_t                   predicted_pc;
  logic  [NUM_SUPER-1:0]   pred_valid;

  // pc, memory interface and rollback
  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) stage_i (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .imem_data     (imem_data),
    .imem_valid    (imem_valid),
    .rollback_en   (rollback_en),
    .rollback_pc   (rollback_pc),
    .predicted_pc  (predicted_pc),
    .pred_valid    (pred_valid),
    .imem_addr     (imem_addr),
    .pc            (pc),
    .slot_inst     (slot_inst),
    .raw_valid     (raw_valid),
    .if_ir         (if_ir),
    .if_valid_inst (if_valid_inst)
  );

  // purely combinational branch guess
  static_predictor predictor_i (
    .pc           (pc),
    .slot_inst    (slot_inst),
    .raw_valid    (raw_valid),
    .if_npc       (if_npc),
    .if_target    (if_target),
    .pred_valid   (pred_valid),
    .predicted_pc (predicted_pc)
  );

endmodule

// ==== hdl/static_predictor.sv ====
/*
  static branch predictor
  decodes both slots, forms next pcs and targets, picks the
  predicted fetch pc and masks the slot behind a taken branch
*/
`timescale 1ns/1ps

module static_predictor (
  input  fetch_pkg::addr_t                             pc,
  input  fetch_pkg::inst_t [fetch_pkg::NUM_SUPER-1:0]  slot_inst,
  input  logic [fetch_pkg::NUM_SUPER-1:0]              raw_valid,
  output fetch_pkg::addr_t [fetch_pkg::NUM_SUPER-1:0]  if_npc,
  output fetch_pkg::addr_t [fetch_pkg::NUM_SUPER-1:0]  if_target,
  output logic [fetch_pkg::NUM_SUPER-1:0]              pred_valid,
  output fetch_pkg::addr_t                             predicted_pc
);
  import fetch_pkg::*;

  // start of the 64-bit word being fetched
  addr_t                 aligned_pc;

  // per slot decode
  opcode_t               slot_op [NUM_SUPER];
  logic [DISP_WIDTH-1:0] slot_disp [NUM_SUPER];
  addr_t                 branch_tgt [NUM_SUPER];

  // BR and BSR
  logic [NUM_SUPER-1:0]  is_uncond;
  // the six compare-with-zero branches
  logic [NUM_SUPER-1:0]  is_cond;
  logic [NUM_SUPER-1:0]  taken;

  // slot 0 is live and redirects fetch
  logic                  shadow;

  assign aligned_pc = {pc[63:3], 3'b000};

  //////////////////////////////////////////////////////////////////////
  // slot decode
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_SUPER; i++)
  begin : g_slot
    assign slot_op[i]   = opcode_t'(slot_inst[i][OPCODE_LSB +: $bits(opcode_t)]);
    assign slot_disp[i] = slot_inst[i][DISP_WIDTH-1:0];

    // fall-through address of each slot
    // slot 0 is word+4, slot 1 is word+8
    assign if_npc[i] = aligned_pc + addr_t'(4 * (i + 1));

    // displacement counts instructions, scale by 4 and sign extend
    assign branch_tgt[i] = if_npc[i] +
      {{($bits(addr_t) - DISP_WIDTH - 2){slot_disp[i][DISP_WIDTH-1]}},
       slot_disp[i], 2'b00};

    // JMP and other indirect forms are not predicted
    // they fall through like any non-branch
    assign is_uncond[i] = (slot_op[i] == OP_BR) || (slot_op[i] == OP_BSR);
    assign is_cond[i]   = slot_op[i] inside {OP_BEQ, OP_BNE, OP_BLT,
                                             OP_BGE, OP_BLE, OP_BGT};

    // backward taken, forward not taken
    // sign bit of the displacement tells the direction
    assign taken[i] = is_uncond[i] || (is_cond[i] && slot_disp[i][DISP_WIDTH-1]);

    // decode gets the predicted successor of each slot
    assign if_target[i] = taken[i] ? branch_tgt[i] : if_npc[i];
  end

  //////////////////////////////////////////////////////////////////////
  // slot masking and next fetch pc
  //////////////////////////////////////////////////////////////////////

  assign shadow = raw_valid[0] && taken[0];

  // slot 0 is never shadowed
  assign pred_valid[0] = raw_valid[0];
  // slot 1 sits on the wrong path once slot 0 jumps away
  assign pred_valid[1] = raw_valid[1] && !shadow;

  // oldest taken branch wins
  // otherwise continue with the next word
  always_comb
  begin
    if (shadow)
    begin
      predicted_pc = branch_tgt[0];
    end
    else if (taken[1])
    begin
      predicted_pc = branch_tgt[1];
    end
    else
    begin
      predicted_pc = if_npc[NUM_SUPER-1];
    end
  end

endmodule

// ==== list.f ====
+incdir+tests
hdl/fetch_pkg.sv
hdl/fetch_stage.sv
hdl/static_predictor.sv
hdl/fetch_unit.sv
tests/fetch_tb.sv

// ==== tests/fetch_model.svh ====
/*
  reference model for the fetch front end
  word base, slot fall-through and branch target, taken rule,
  expected slot validity and next fetch pc
*/
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// start of the 64-bit word that holds pc
function automatic addr_t word_base(addr_t pc);
  return pc & ~addr_t'(7);
endfunction

// slot 0 falls through to word+4, slot 1 to word+8
function automatic addr_t fall_through(addr_t pc, int slot);
  return word_base(pc) + addr_t'(4 * slot + 4);
endfunction

// BR and BSR always, conditional branches only when backward
function automatic bit predict_taken(inst_t inst);
  bit result;
  case (inst[OPCODE_LSB +: 6])
    6'h30, 6'h34: result = 1'b1;
    6'h39, 6'h3a, 6'h3b, 6'h3d, 6'h3e, 6'h3f: result = inst[DISP_WIDTH-1];
    default: result = 1'b0;
  endcase
  return result;
endfunction

// displacement is a signed count of instructions past the fall-through
function automatic addr_t branch_dest(addr_t pc, int slot, inst_t inst);
  longint disp;
  disp = longint'(inst[DISP_WIDTH-1:0]);
  if (inst[DISP_WIDTH-1])
  begin
    disp = disp - (longint'(1) << DISP_WIDTH);
  end
  return fall_through(pc, slot) + addr_t'(disp * 4);
endfunction

// valid bits as decode should see them
function automatic logic [1:0] slot_valid(addr_t pc, bit word_ok, bit redirect, inst_t inst0);
  logic [1:0] v;
  v = 2'b00;
  if (word_ok && !redirect)
  begin
    v[0] = !pc[2];
    v[1] = !(v[0] && predict_taken(inst0));
  end
  return v;
endfunction

// fetch pc after an enabled cycle without rollback
function automatic addr_t next_fetch(addr_t pc, inst_t inst0, inst_t inst1);
  if (!pc[2] && predict_taken(inst0))
  begin
    return branch_dest(pc, 0, inst0);
  end
  if (predict_taken(inst1))
  begin
    return branch_dest(pc, 1, inst1);
  end
  return word_base(pc) + addr_t'(8);
endfunction

`endif

// ==== tests/fetch_tb.sv ====
/*
  testbench for the fetch unit
  clock and reset, random program memory, random stall and rollback
  stimulus, per-cycle checks against the reference model
*/
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int FETCHES    = 3000;
  localparam int MAX_CYCLES = 20000;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  get_next_inst;
  logic                  rollback_en;
  addr_t                 rollback_pc;
  logic [63:0]           imem_data;
  logic                  imem_valid;
  addr_t                 imem_addr;
  inst_t [NUM_SUPER-1:0] if_ir;
  addr_t [NUM_SUPER-1:0] if_npc;
  addr_t [NUM_SUPER-1:0] if_target;
  logic  [NUM_SUPER-1:0] if_valid_inst;

  // program image, one 64-bit word per entry
  logic [63:0] mem [MEM_WORDS];
  // model pc now and after the coming edge
  addr_t exp_pc;
  addr_t pending_pc;
  int    error_count = 0;
  // how often each interesting case came up
  int    taken_seen = 0;
  int    stall_seen = 0;
  int    rollback_seen = 0;
  int    upper_seen = 0;

  `include "fetch_model.svh"

  always #10 clock = ~clock;

  // same-cycle memory, address wraps on the array size
  assign imem_data = mem[imem_addr[10:3]];

  fetch_unit dut_i (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .rollback_en   (rollback_en),
    .rollback_pc   (rollback_pc),
    .imem_data     (imem_data),
    .imem_valid    (imem_valid),
    .imem_addr     (imem_addr),
    .if_ir         (if_ir),
    .if_npc        (if_npc),
    .if_target     (if_target),
    .if_valid_inst (if_valid_inst)
  );

  task automatic fail_run(string what);
    error_count++;
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] want);
    assert (got === want)
    else
    begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, want));
    end
  endtask

  // a third are branches with a short displacement of either sign
  function automatic inst_t random_inst();
    logic [5:0] branch_ops [9] = '{6'h30, 6'h34, 6'h39, 6'h3a, 6'h3b,
                                   6'h3d, 6'h3e, 6'h3f, 6'h1a};
    inst_t inst;
    int    disp;
    int    pick;
    inst = $urandom;
    if ($urandom_range(2) == 0)
    begin
      pick = $urandom_range(8);
      disp = $urandom_range(32) - 16;
      inst[OPCODE_LSB +: 6] = branch_ops[pick];
      inst[DISP_WIDTH-1:0] = disp[DISP_WIDTH-1:0];
    end
    return inst;
  endfunction

  task automatic drive_inputs();
    imem_valid    <= ($urandom_range(99) >= 20);
    get_next_inst <= ($urandom_range(99) >= 15);
    rollback_en   <= ($urandom_range(99) < 5);
    rollback_pc   <= {$urandom, $urandom} & ~addr_t'(3);
  endtask

  // compare all outputs, then work out the pc for the next edge
  task automatic check_cycle();
    logic [63:0] word;
    inst_t       inst [NUM_SUPER];
    logic [1:0]  valid;
    word = mem[exp_pc[10:3]];
    check_value("imem_addr", imem_addr, word_base(exp_pc));
    for (int i = 0; i < NUM_SUPER; i++)
    begin
      inst[i] = word[32*i +: 32];
    end
    valid = slot_valid(exp_pc, imem_valid, rollback_en, inst[0]);
    check_value("if_valid_inst", 64'(if_valid_inst), 64'(valid));
    for (int i = 0; i < NUM_SUPER; i++)
    begin
      check_value($sformatf("if_ir[%0d]", i), 64'(if_ir[i]), 64'(inst[i]));
      check_value($sformatf("if_npc[%0d]", i), if_npc[i], fall_through(exp_pc, i));
      check_value($sformatf("if_target[%0d]", i), if_target[i],
                  predict_taken(inst[i]) ? branch_dest(exp_pc, i, inst[i])
                                         : fall_through(exp_pc, i));
      if (valid[i] && predict_taken(inst[i]))
      begin
        taken_seen++;
      end
    end
    // rollback beats a stall, a stall holds the pc
    if (rollback_en)
    begin
      pending_pc = rollback_pc;
      rollback_seen++;
    end
    else if (imem_valid && get_next_inst)
    begin
      pending_pc = next_fetch(exp_pc, inst[0], inst[1]);
    end
    else
    begin
      pending_pc = exp_pc;
      stall_seen++;
    end
    if (imem_valid && exp_pc[2])
    begin
      upper_seen++;
    end
  endtask

  initial
  begin
    int fetches;
    int cycles;
    void'($urandom(32'h2168_1d54));
    reset = 1'b1;
    get_next_inst = 1'b0;
    rollback_en = 1'b0;
    rollback_pc = '0;
    imem_valid = 1'b0;
    for (int w = 0; w < MEM_WORDS; w++)
    begin
      mem[w] = {random_inst(), random_inst()};
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    exp_pc = '0;
    // first look after reset, memory still quiet
    @(negedge clock);
    check_cycle();
    fetches = 0;
    cycles = 0;
    while (fetches < FETCHES)
    begin
      if (cycles >= MAX_CYCLES)
      begin
        fail_run($sformatf("timeout after %0d clocks with only %0d of %0d fetch cycles",
                           cycles, fetches, FETCHES));
      end
      @(posedge clock);
      exp_pc = pending_pc;
      drive_inputs();
      @(negedge clock);
      check_cycle();
      if (imem_valid && get_next_inst)
      begin
        fetches++;
      end
      cycles++;
    end
    assert (taken_seen > 0 && stall_seen > 0 && rollback_seen > 0 && upper_seen > 0)
    else
    begin
      fail_run("the run never hit a taken branch, stall, rollback or upper-half entry");
    end
    if (error_count == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("STATUS: FAIL");
      $fatal(1, "errors were found");
    end
  end

endmodule
